// ==== logic/pic_pkg.sv ====
package pic_pkg;

    // register window offsets, any other paddr value is an error
    localparam logic [7:0] ADDR_COMMAND = 8'd0;
    localparam logic [7:0] ADDR_DATA    = 8'd1;

    // fixed by the 3-bit line index carried in the vector
    localparam int NUM_LINES = 8;

    // initialisation sequence, ICW3 is skipped since there is no cascade
    typedef enum logic [2:0] {
        INIT_ICW1,
        INIT_ICW2,
        INIT_ICW4,
        INIT_IDLE
    } init_state_e;

    // what a read of the command register returns
    typedef enum logic [1:0] {
        READ_NONE,
        READ_IRR,
        READ_ISR
    } read_sel_e;

    // OCW2 code field in data bits 7 to 5, unlisted codes are ignored
    typedef enum logic [2:0] {
        EOI_NONSPECIFIC = 3'b001,
        EOI_SPECIFIC    = 3'b011
    } ocw_cmd_e;

    // register state and command pulses from decode
    typedef struct packed {
        logic       eoi_nonspecific;
        logic       eoi_specific;
        logic [2:0] eoi_line;
        logic [4:0] vector_base;
        logic [7:0] mask;
        read_sel_e  read_sel;
    } pic_cmd_t;

    // request and service registers from execute
    typedef struct packed {
        logic [7:0] irr;
        logic [7:0] isr;
    } pic_status_t;

    // APB phase and address decode from decode
    typedef struct packed {
        logic access;
        logic read;
        logic bad_addr;
        logic addr_data;
    } pic_bus_t;

endpackage

// ==== logic/pic_decode.sv ====
`timescale 1ns/1ps

module pic_decode (
    input  logic              clk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [7:0]        paddr,
    input  logic [7:0]        pwdata,
    output pic_pkg::pic_cmd_t cmd,
    output pic_pkg::pic_bus_t bus
);

    pic_pkg::init_state_e init_state;
    pic_pkg::init_state_e init_next;
    pic_pkg::read_sel_e   read_sel;
    pic_pkg::read_sel_e   read_sel_next;
    pic_pkg::ocw_cmd_e    ocw_cmd;

    logic [4:0] vector_base;
    logic [7:0] mask;

    logic access;
    logic hit_command;
    logic hit_data;
    logic wr_command;
    logic wr_data;
    logic in_idle;
    logic icw1_write;
    logic ocw2_write;
    logic ocw3_write;

    // with no wait states the access phase is a single cycle,
    // so every write completes on the edge that ends it
    assign access      = psel & penable;
    assign hit_command = (paddr == pic_pkg::ADDR_COMMAND);
    assign hit_data    = (paddr == pic_pkg::ADDR_DATA);
    assign wr_command  = access & pwrite & hit_command;
    assign wr_data     = access & pwrite & hit_data;
    assign in_idle     = (init_state == pic_pkg::INIT_IDLE);

    // bit 4 marks ICW1 whatever state we are in
    assign icw1_write = wr_command & pwdata[4];
    assign ocw3_write = wr_command & in_idle & ~pwdata[4] & pwdata[3];
    assign ocw2_write = wr_command & in_idle & (pwdata[4:3] == 2'b00);

    assign ocw_cmd = pic_pkg::ocw_cmd_e'(pwdata[7:5]);

    always_comb begin
        init_next = init_state;
        if (icw1_write) begin
            init_next = pic_pkg::INIT_ICW2;
        end else begin
            case (init_state)
                pic_pkg::INIT_ICW2: begin
                    if (wr_data) begin
                        init_next = pic_pkg::INIT_ICW4;
                    end
                end
                pic_pkg::INIT_ICW4: begin
                    if (wr_data) begin
                        init_next = pic_pkg::INIT_IDLE;
                    end
                end
                default: begin
                    init_next = init_state;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            init_state <= pic_pkg::INIT_ICW1;
        end else begin
            init_state <= init_next;
        end
    end

    // ICW2 carries the vector base in its top five bits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vector_base <= 5'd0;
        end else if (wr_data && init_state == pic_pkg::INIT_ICW2) begin
            vector_base <= pwdata[7:3];
        end
    end

    // all lines stay disabled until the host writes a mask
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mask <= 8'd0;
        end else if (wr_data && in_idle) begin
            mask <= pwdata;
        end
    end

    always_comb begin
        case (pwdata[1:0])
            2'b10:   read_sel_next = pic_pkg::READ_IRR;
            2'b11:   read_sel_next = pic_pkg::READ_ISR;
            default: read_sel_next = pic_pkg::READ_NONE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            read_sel <= pic_pkg::READ_NONE;
        end else if (ocw3_write) begin
            read_sel <= read_sel_next;
        end
    end

    // EOI pulses last exactly the one access cycle of the write
    assign cmd.eoi_nonspecific = ocw2_write & (ocw_cmd == pic_pkg::EOI_NONSPECIFIC);
    assign cmd.eoi_specific    = ocw2_write & (ocw_cmd == pic_pkg::EOI_SPECIFIC);
    assign cmd.eoi_line        = pwdata[2:0];
    assign cmd.vector_base     = vector_base;
    assign cmd.mask            = mask;
    assign cmd.read_sel        = read_sel;

    assign bus.access    = access;
    assign bus.read      = ~pwrite;
    assign bus.bad_addr  = ~(hit_command | hit_data);
    assign bus.addr_data = hit_data;

    // an EOI pulse lasts one cycle because APB puts a setup or idle cycle after every access
    a_eoi_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        (cmd.eoi_nonspecific || cmd.eoi_specific)
            |=> !(cmd.eoi_nonspecific || cmd.eoi_specific)
    );

endmodule

// ==== logic/pic_execute.sv ====
`timescale 1ns/1ps

module pic_execute (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [7:0]           intr_in,
    input  logic                 inta,
    input  pic_pkg::pic_cmd_t    cmd,
    output pic_pkg::pic_status_t status,
    output logic                 intr,
    output logic [2:0]           line
);

    logic [7:0] intr_sample;
    logic [7:0] intr_last;
    logic [7:0] edges;
    logic [7:0] irr;
    logic [7:0] isr;
    logic [7:0] isr_after_eoi;
    logic [7:0] won_onehot;
    logic [2:0] winner;
    logic [2:0] won_line;
    logic       pending;
    logic       stop;
    logic       won_valid;
    logic       ack;

    // the input is sampled once, then compared with the previous sample,
    // which puts the IRR update one edge after the sampling edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            intr_sample <= 8'd0;
            intr_last   <= 8'd0;
        end else begin
            intr_sample <= intr_in;
            intr_last   <= intr_sample;
        end
    end

    assign edges = intr_sample & ~intr_last;

    // scan from line 0, a line in service blocks itself and everything below it
    always_comb begin
        stop    = 1'b0;
        pending = 1'b0;
        winner  = 3'd0;
        for (int i = 0; i < pic_pkg::NUM_LINES; i++) begin
            if (!stop) begin
                if (isr[i]) begin
                    stop = 1'b1;
                end else if (irr[i]) begin
                    stop    = 1'b1;
                    pending = 1'b1;
                    winner  = 3'(i);
                end
            end
        end
    end

    // the host acknowledges what it saw as the winner one cycle earlier
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            won_line  <= 3'd0;
            won_valid <= 1'b0;
        end else begin
            won_line  <= winner;
            won_valid <= pending;
        end
    end

    assign ack        = inta & won_valid;
    assign won_onehot = 8'd1 << won_line;

    // edges arriving during an acknowledge are dropped
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            irr <= 8'd0;
        end else if (inta) begin
            if (ack) begin
                irr <= irr & ~won_onehot;
            end
        end else begin
            irr <= irr | (edges & cmd.mask);
        end
    end

    always_comb begin
        isr_after_eoi = isr;
        if (cmd.eoi_nonspecific) begin
            // x & (x - 1) drops the lowest set bit, which is the highest priority
            isr_after_eoi = isr & (isr - 8'd1);
        end else if (cmd.eoi_specific) begin
            isr_after_eoi[cmd.eoi_line] = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            isr <= 8'd0;
        end else if (ack) begin
            isr <= isr_after_eoi | won_onehot;
        end else begin
            isr <= isr_after_eoi;
        end
    end

    assign intr       = pending & ~inta;
    assign line       = winner;
    assign status.irr = irr;
    assign status.isr = isr;

    // an acknowledge only moves a request that is still pending and not yet in service
    a_ack_from_pending: assert property (
        @(posedge clk) disable iff (reset)
        ack |-> (irr[won_line] && !isr[won_line])
    );

    // a line only enters service through an acknowledge
    a_isr_set_by_inta: assert property (
        @(posedge clk) disable iff (reset)
        (|(status.isr & ~$past(status.isr))) |-> $past(inta)
    );

endmodule

// ==== logic/pic_result.sv ====
`timescale 1ns/1ps

module pic_result (
    input  pic_pkg::pic_bus_t    bus,
    input  pic_pkg::pic_cmd_t    cmd,
    input  pic_pkg::pic_status_t status,
    input  logic [2:0]           line,
    input  logic                 intr,
    output logic [7:0]           prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic [7:0]           vector
);

    logic [7:0] command_val;
    logic       good_read;

    // the command register shows whichever of IRR and ISR OCW3 picked
    always_comb begin
        case (cmd.read_sel)
            pic_pkg::READ_IRR: command_val = status.irr;
            pic_pkg::READ_ISR: command_val = status.isr;
            default:           command_val = 8'd0;
        endcase
    end

    assign good_read = bus.access & bus.read & ~bus.bad_addr;

    // read data is only driven during a valid access, zero otherwise
    always_comb begin
        if (!good_read) begin
            prdata = 8'd0;
        end else if (bus.addr_data) begin
            prdata = cmd.mask;
        end else begin
            prdata = command_val;
        end
    end

    // no wait states, every access phase completes at once
    assign pready  = bus.access;
    assign pslverr = bus.access & bus.bad_addr;

    // base in the top five bits, line number in the bottom three
    assign vector = intr ? {cmd.vector_base, line} : 8'd0;

endmodule

// ==== logic/pic_top.sv ====
`timescale 1ns/1ps

module pic_top (
    input  logic       clk,
    input  logic       reset,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [7:0] paddr,
    input  logic [7:0] pwdata,
    output logic [7:0] prdata,
    output logic       pready,
    output logic       pslverr,
    input  logic [7:0] intr_in,
    input  logic       inta,
    output logic       intr,
    output logic [7:0] vector
);

    pic_pkg::pic_cmd_t    cmd;
    pic_pkg::pic_bus_t    bus;
    pic_pkg::pic_status_t status;
    logic [2:0]           line;

    pic_decode u_decode (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .cmd     (cmd),
        .bus     (bus)
    );

    pic_execute u_execute (
        .clk     (clk),
        .reset   (reset),
        .intr_in (intr_in),
        .inta    (inta),
        .cmd     (cmd),
        .status  (status),
        .intr    (intr),
        .line    (line)
    );

    pic_result u_result (
        .bus     (bus),
        .cmd     (cmd),
        .status  (status),
        .line    (line),
        .intr    (intr),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .vector  (vector)
    );

endmodule

// ==== verification/pic_tb.sv ====
`timescale 1ns/1ps

module pic_tb;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 2000;

    logic       clk;
    logic       reset;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [7:0] paddr;
    logic [7:0] pwdata;
    logic [7:0] prdata;
    logic       pready;
    logic       pslverr;
    logic [7:0] intr_in;
    logic       inta;
    logic       intr;
    logic [7:0] vector;

    // expected controller state, advanced alongside the stimulus
    logic [7:0]  m_irr;
    logic [7:0]  m_isr;
    logic [7:0]  m_mask;
    logic [4:0]  m_base;
    logic [31:0] rng_state;
    int          errors;
    int          tests_failed;

    pic_top uut (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .intr_in (intr_in),
        .inta    (inta),
        .intr    (intr),
        .vector  (vector)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [7:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];
    endfunction

    // index of the lowest set bit, 8 when the value is empty
    function automatic int lowest_bit(input logic [7:0] value);
        int found;
        found = 8;
        for (int i = 7; i >= 0; i--) begin
            if (value[i]) begin
                found = i;
            end
        end
        return found;
    endfunction

    // a request is presented only when it outranks every line in service
    function automatic logic [8:0] predict(input logic [7:0] irr, input logic [7:0] isr,
                                           input logic [4:0] base);
        int req_line;
        int svc_line;
        req_line = lowest_bit(irr);
        svc_line = lowest_bit(isr);
        if (req_line < svc_line) begin
            return {1'b1, base, req_line[2:0]};
        end
        return 9'd0;
    endfunction

    task automatic compare(input string name, input logic [7:0] actual,
                           input logic [7:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic apb_access(input logic is_write, input logic [7:0] addr,
                              input logic [7:0] wdata, output logic [7:0] rdata,
                              output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= is_write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waited < 16) begin
            waited++;
            @(negedge clk);
        end
        if (!pready) begin
            $display("APB transfer to address %h never completed", addr);
            errors++;
        end
        // sampled mid-cycle, before the edge that completes the access
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [7:0] wdata);
        logic [7:0] rdata;
        logic       err;
        apb_access(1'b1, addr, wdata, rdata, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [7:0] rdata);
        logic err;
        apb_access(1'b0, addr, 8'h00, rdata, err);
    endtask

    // an edge is sampled, then lands in IRR one edge later
    task automatic drive_lines(input logic [7:0] value);
        logic [7:0] rising;
        rising = value & ~intr_in;
        @(posedge clk);
        intr_in <= value;
        repeat (3) @(posedge clk);
        m_irr = m_irr | (rising & m_mask);
    endtask

    task automatic acknowledge();
        logic [8:0] expect_out;
        expect_out = predict(m_irr, m_isr, m_base);
        @(posedge clk);
        inta <= 1'b1;
        @(negedge clk);
        compare("intr during inta", {7'd0, intr}, 8'd0);
        @(posedge clk);
        inta <= 1'b0;
        if (expect_out[8]) begin
            m_irr[expect_out[2:0]] = 1'b0;
            m_isr[expect_out[2:0]] = 1'b1;
        end
    endtask

    task automatic end_of_interrupt(input logic specific, input logic [2:0] eoi_line);
        int lowest;
        if (specific) begin
            apb_write(pic_pkg::ADDR_COMMAND, {3'b011, 2'b00, eoi_line});
            m_isr[eoi_line] = 1'b0;
        end else begin
            apb_write(pic_pkg::ADDR_COMMAND, 8'h20);
            lowest = lowest_bit(m_isr);
            if (lowest < 8) begin
                m_isr[lowest[2:0]] = 1'b0;
            end
        end
    endtask

    // empty ISR first, then service and retire each remaining request
    task automatic retire_all();
        for (int i = 0; i < 8; i++) begin
            if (m_isr[i]) begin
                end_of_interrupt(1'b1, 3'(i));
            end
        end
        for (int n = 0; n < 8; n++) begin
            if (m_irr != 8'd0) begin
                acknowledge();
                end_of_interrupt(1'b0, 3'd0);
            end
        end
    endtask

    task automatic check_outputs();
        logic [8:0] expect_out;
        expect_out = predict(m_irr, m_isr, m_base);
        @(negedge clk);
        compare("intr", {7'd0, intr}, {7'd0, expect_out[8]});
        compare("vector", vector, expect_out[7:0]);
    endtask

    // OCW3 picks IRR, then ISR, for the command register readback
    task automatic check_state();
        logic [7:0] rdata;
        check_outputs();
        apb_write(pic_pkg::ADDR_COMMAND, 8'h0a);
        apb_read(pic_pkg::ADDR_COMMAND, rdata);
        compare("irr", rdata, m_irr);
        apb_write(pic_pkg::ADDR_COMMAND, 8'h0b);
        apb_read(pic_pkg::ADDR_COMMAND, rdata);
        compare("isr", rdata, m_isr);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    initial begin
        logic [7:0] rdata;
        logic [7:0] value;
        logic [7:0] wdata;
        logic [2:0] pick;
        logic       err;
        int         mark;
        reset        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = 8'h00;
        pwdata       = 8'h00;
        intr_in      = 8'h00;
        inta         = 1'b0;
        m_irr        = 8'h00;
        m_isr        = 8'h00;
        m_mask       = 8'h00;
        m_base       = 5'd0;
        rng_state    = 32'h35266694;
        errors       = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        mark   = errors;
        value  = next_random();
        m_base = value[4:0];
        apb_write(pic_pkg::ADDR_COMMAND, 8'h11);
        apb_write(pic_pkg::ADDR_DATA, {m_base, 3'b000});
        apb_write(pic_pkg::ADDR_DATA, 8'h01);
        m_mask = next_random();
        apb_write(pic_pkg::ADDR_DATA, m_mask);
        apb_read(pic_pkg::ADDR_DATA, rdata);
        compare("mask readback", rdata, m_mask);
        // pending requests stay hidden while OCW3 has selected nothing
        drive_lines(m_mask);
        apb_read(pic_pkg::ADDR_COMMAND, rdata);
        compare("command readback", rdata, 8'h00);
        check_state();
        drive_lines(8'd0);
        retire_all();
        report_test("init and readback", mark);

        // a pulse on a disabled line must be lost, a held line requests once
        mark   = errors;
        value  = next_random();
        pick   = value[2:0];
        m_mask = ~(8'd1 << pick);
        apb_write(pic_pkg::ADDR_DATA, m_mask);
        drive_lines(8'd1 << pick);
        drive_lines(8'd0);
        check_state();
        m_mask = 8'hff;
        apb_write(pic_pkg::ADDR_DATA, m_mask);
        drive_lines(8'd1 << pick);
        check_state();
        acknowledge();
        check_state();
        end_of_interrupt(1'b1, pick);
        repeat (4) @(posedge clk);
        check_state();
        drive_lines(8'd0);
        report_test("masking and edges", mark);

        mark = errors;
        for (int round = 0; round < 10; round++) begin
            drive_lines(next_random());
            check_outputs();
            acknowledge();
            check_state();
            value = next_random();
            if (value[0]) begin
                end_of_interrupt(1'b0, 3'd0);
                check_outputs();
            end
        end
        report_test("priority and vector", mark);

        // empty both registers, then stack lines in service from 7 down to 0
        mark = errors;
        drive_lines(8'd0);
        retire_all();
        value = next_random() | 8'h81;
        for (int i = 7; i >= 0; i--) begin
            if (value[i]) begin
                drive_lines(8'd1 << i);
                acknowledge();
            end
        end
        check_state();
        drive_lines(next_random());
        check_outputs();
        end_of_interrupt(1'b0, 3'd0);
        check_state();
        value = next_random();
        pick  = value[2:0];
        for (int k = 0; k < 8; k++) begin
            if (m_isr[pick]) begin
                end_of_interrupt(1'b1, pick);
                check_state();
            end
            pick = pick + 3'd1;
        end
        drive_lines(8'd0);
        report_test("end of interrupt", mark);

        mark = errors;
        for (int n = 0; n < 4; n++) begin
            value = next_random();
            if (value < 8'd2) begin
                value = value + 8'd2;
            end
            wdata = next_random() | 8'h10;
            apb_access(1'b1, value, wdata, rdata, err);
            compare("pslverr on bad write", {7'd0, err}, 8'd1);
            apb_access(1'b0, value, 8'h00, rdata, err);
            compare("pslverr on bad read", {7'd0, err}, 8'd1);
        end
        apb_access(1'b0, pic_pkg::ADDR_DATA, 8'h00, rdata, err);
        compare("mask after bad accesses", rdata, m_mask);
        compare("pslverr on data register", {7'd0, err}, 8'd0);
        apb_access(1'b0, pic_pkg::ADDR_COMMAND, 8'h00, rdata, err);
        compare("pslverr on command register", {7'd0, err}, 8'd0);
        check_state();
        report_test("error response", mark);

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
logic/pic_pkg.sv
logic/pic_decode.sv
logic/pic_execute.sv
logic/pic_result.sv
logic/pic_top.sv
verification/pic_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := pic_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TESTS PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
